//--- design/controlDecoder.sv
// Combinational opcode and function decoder: control bundle, call flag, register read addresses
module controlDecoder (
	input decodePkg::dataT instruction,
	output decodePkg::ctrlT ctrl,
	output logic callCmd,
	output decodePkg::regAddrT src0Addr,
	output logic src0En,
	output decodePkg::regAddrT src1Addr,
	output logic src1En
);
	import decodePkg::*;

	opcodeE opcode;
	functE funct;
	regAddrT rs;
	regAddrT rt;
	regAddrT rd;
	logic [4:0] shamt;

	assign opcode = opcodeE'(instruction[31:26]);
	assign funct = functE'(instruction[5:0]);
	assign rs = instruction[25:21];
	assign rt = instruction[20:16];
	assign rd = instruction[15:11];
	assign shamt = instruction[10:6];

	// ALU operation for each R-type function
	function automatic aluOpE aluForFunct(functE fn);
		case (fn)
			fnAdd: return aluAdd;
			fnSub: return aluSub;
			fnAnd: return aluAnd;
			fnOr: return aluOr;
			fnXor: return aluXor;
			fnSlt: return aluSlt;
			fnSll: return aluSll;
			fnSrl: return aluSrl;
			default: return aluPass;
		endcase
	endfunction

	always_comb begin
		logic rTypeValid;
		rTypeValid = 1'b0;
		ctrl = '0;
		callCmd = 1'b0;
		src0Addr = rs;
		src1Addr = rt;
		src0En = 1'b0;
		src1En = 1'b0;
		case (opcode)
			opRType: begin
				case (funct)
					fnAdd, fnSub, fnSlt: begin
						rTypeValid = 1'b1;
						src0En = 1'b1;
						ctrl.zeroEn = 1'b1;
						ctrl.overflowEn = 1'b1;
						ctrl.negativeEn = 1'b1;
					end
					fnAnd, fnOr, fnXor: begin
						rTypeValid = 1'b1;
						src0En = 1'b1;
						ctrl.zeroEn = 1'b1;
					end
					// Shifts operate on rt only
					fnSll, fnSrl: begin
						rTypeValid = 1'b1;
						ctrl.exuOp = exuShifter;
						ctrl.exuShift = shamt;
					end
					default: ;
				endcase
				if (rTypeValid) begin
					ctrl.aluOp = aluForFunct(funct);
					ctrl.aluCmd = 1'b1;
					ctrl.writeAddr = rd;
					ctrl.writeEn = 1'b1;
					src1En = 1'b1;
				end
			end
			opAddi, opAndi, opOri: begin
				src0En = 1'b1;
				ctrl.aluCmd = 1'b1;
				ctrl.writeAddr = rt;
				ctrl.writeEn = 1'b1;
				ctrl.zeroEn = 1'b1;
				if (opcode == opAddi) begin
					ctrl.aluOp = aluAdd;
					ctrl.overflowEn = 1'b1;
					ctrl.negativeEn = 1'b1;
				end else begin
					ctrl.aluOp = (opcode == opAndi) ? aluAnd : aluOr;
				end
			end
			opLoad: begin
				src0En = 1'b1;
				ctrl.exuOp = exuMemory;
				ctrl.loadCmd = 1'b1;
				ctrl.memValid = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.writeAddr = rt;
				ctrl.writeEn = 1'b1;
			end
			opStore: begin
				src0En = 1'b1;
				src1En = 1'b1;
				ctrl.exuOp = exuMemory;
				ctrl.storeCmd = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.memValid = 1'b1;
			end
			opBeq, opBne: begin
				src0En = 1'b1;
				src1En = 1'b1;
				ctrl.aluOp = aluSub;
				ctrl.exuOp = exuControl;
				ctrl.branchOp = (opcode == opBeq) ? brEq : brNe;
				ctrl.branchCmd = 1'b1;
			end
			opJump: begin
				ctrl.exuOp = exuControl;
				ctrl.branchOp = brAlways;
				ctrl.jumpCmd = 1'b1;
			end
			// Stack push of the return address with data a cycle later
			opCall: begin
				ctrl.exuOp = exuControl;
				ctrl.branchOp = brAlways;
				ctrl.memValid = 1'b1;
				callCmd = 1'b1;
			end
			opRet: begin
				ctrl.exuOp = exuControl;
				ctrl.branchOp = brAlways;
				ctrl.memValid = 1'b1;
				ctrl.retCmd = 1'b1;
			end
			opHalt: ctrl.halt = 1'b1;
			default: ;
		endcase
	end

endmodule

//--- design/decodeDefs.svh
// Width and count macros for the decode stage: data word, register address, register count
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// Machine word, also the program counter width
`define DATA_WIDTH 32

// Register index width
`define REG_ADDR_WIDTH 5

// Entries in the register file
`define REG_COUNT 32

`endif

//--- design/decodePkg.sv
// Decode types: word and register index, opcode/function/ALU/branch enums, control and operand structs
package decodePkg;

	`include "decodeDefs.svh"

	typedef logic [`DATA_WIDTH-1:0] dataT;
	typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;

	// Primary opcode, bits 31:26
	typedef enum logic [5:0] {
		opRType = 6'd0,
		opJump = 6'd2,
		opCall = 6'd3,
		opBeq = 6'd4,
		opBne = 6'd5,
		opAddi = 6'd8,
		opAndi = 6'd12,
		opOri = 6'd13,
		opRet = 6'd16,
		opLoad = 6'd35,
		opStore = 6'd43,
		opHalt = 6'd63
	} opcodeE;

	// R-type function, bits 5:0
	typedef enum logic [5:0] {
		fnSll = 6'd0,
		fnSrl = 6'd2,
		fnAdd = 6'd32,
		fnSub = 6'd34,
		fnAnd = 6'd36,
		fnOr = 6'd37,
		fnXor = 6'd38,
		fnSlt = 6'd42
	} functE;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSll, aluSrl, aluPass
	} aluOpE;

	typedef enum logic [1:0] {exuAlu, exuShifter, exuMemory, exuControl} exuOpE;

	typedef enum logic [2:0] {brNone, brEq, brNe, brAlways} branchOpE;

	typedef struct packed {
		aluOpE aluOp;
		exuOpE exuOp;
		logic [4:0] exuShift;
		branchOpE branchOp;
		logic branchCmd;
		logic jumpCmd;
		logic retCmd;
		logic aluCmd;
		logic halt;
		logic memWrite;
		logic memValid;
		logic memToReg;
		logic loadCmd;
		logic storeCmd;
		logic zeroEn;
		logic overflowEn;
		logic negativeEn;
		regAddrT writeAddr;
		logic writeEn;
	} ctrlT;

	typedef struct packed {
		dataT src0;
		dataT src1;
		dataT immediate;
		dataT branchAddr;
	} operandT;

endpackage

//--- design/decodeStage.sv
// Instruction decode stage top: decoder, register file, immediate, branch target, call store data
module decodeStage (
	input logic iClk,
	input logic rstN,
	input decodePkg::dataT instruction,
	input decodePkg::dataT nextPC,
	input logic branchPredict,
	input decodePkg::regAddrT writeAddr,
	input decodePkg::dataT writeData,
	input logic writeEn,
	output decodePkg::ctrlT ctrl,
	output decodePkg::operandT operands,
	output decodePkg::dataT memData,
	output logic callCmd,
	output decodePkg::dataT nextPCOut,
	output logic branchPredictOut,
	output decodePkg::dataT instructionOut
);
	import decodePkg::*;

	`include "decodeDefs.svh"

	regAddrT src0Addr;
	regAddrT src1Addr;
	logic src0En;
	logic src1En;
	logic callDecoded;
	dataT src0;
	dataT src1;
	dataT immExt;
	dataT nextPCReg;
	logic callReg;

	controlDecoder decoder (
		.instruction(instruction),
		.ctrl(ctrl),
		.callCmd(callDecoded),
		.src0Addr(src0Addr),
		.src0En(src0En),
		.src1Addr(src1Addr),
		.src1En(src1En)
	);

	registerFile regFile (
		.iClk(iClk),
		.rstN(rstN),
		.readAddr0(src0Addr),
		.readEn0(src0En),
		.readAddr1(src1Addr),
		.readEn1(src1En),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.writeEn(writeEn),
		.readData0(src0),
		.readData1(src1)
	);

	assign immExt = {{(`DATA_WIDTH - 16){instruction[15]}}, instruction[15:0]};

	// Word offset from the next PC
	assign operands = '{
		src0: src0,
		src1: src1,
		immediate: immExt,
		branchAddr: nextPC + (immExt << 2)
	};

	// Return address pushed the cycle after a call
	always_ff @(posedge iClk or negedge rstN) begin
		if (!rstN) begin
			callReg <= 1'b0;
			nextPCReg <= '0;
		end else begin
			callReg <= callDecoded;
			nextPCReg <= nextPC;
		end
	end

	assign memData = callReg ? nextPCReg : src1;
	assign callCmd = callReg;
	assign nextPCOut = nextPC;
	assign branchPredictOut = branchPredict;
	assign instructionOut = instruction;

	callDelay: assert property (@(posedge iClk) disable iff (!rstN)
		((instruction[31:26] == opCall) |=> callCmd)
		and ((instruction[31:26] != opCall) |=> !callCmd))
		else $error("decodeStage: call flag not delayed by exactly one cycle");

endmodule

//--- design/registerFile.sv
// Register file: 32 words, two gated read ports, one write port, zero register, write-through bypass
module registerFile (
	input logic iClk,
	input logic rstN,
	input decodePkg::regAddrT readAddr0,
	input logic readEn0,
	input decodePkg::regAddrT readAddr1,
	input logic readEn1,
	input decodePkg::regAddrT writeAddr,
	input decodePkg::dataT writeData,
	input logic writeEn,
	output decodePkg::dataT readData0,
	output decodePkg::dataT readData1
);
	import decodePkg::*;

	`include "decodeDefs.svh"

	dataT regs [`REG_COUNT];

	// Register 0 is never written
	always_ff @(posedge iClk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// One read port with bypass of a write to the same address
	function automatic dataT readPort(regAddrT addr, logic en);
		if (!en || addr == '0)
			return '0;
		if (writeEn && addr == writeAddr)
			return writeData;
		return regs[addr];
	endfunction

	always_comb begin
		readData0 = readPort(readAddr0, readEn0);
		readData1 = readPort(readAddr1, readEn1);
	end

endmodule

//--- files.f
+incdir+design
design/decodePkg.sv
design/controlDecoder.sv
design/registerFile.sv
design/decodeStage.sv
test/decodeStageTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the decode stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f files.f --top-module decodeStageTb -Mdir obj_dir -o decodeStageSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/decodeStageSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
	exit 1
fi
exit 0

//--- test/decodeStageTb.sv
// Decode stage testbench: clock, reset, directed tests, typed compare tasks, error summary
module decodeStageTb;
	timeunit 1ns;
	timeprecision 1ps;

	import decodePkg::*;

	logic iClk;
	logic rstN;
	dataT instruction;
	dataT nextPC;
	logic branchPredict;
	regAddrT writeAddr;
	dataT writeData;
	logic writeEn;
	ctrlT ctrl;
	operandT operands;
	dataT memData;
	logic callCmd;
	dataT nextPCOut;
	logic branchPredictOut;
	dataT instructionOut;

	integer seed;
	int errors;
	int timeouts;
	logic resetDone;
	// Expected register contents
	dataT model [32];

	decodeStage UUT (
		.iClk(iClk),
		.rstN(rstN),
		.instruction(instruction),
		.nextPC(nextPC),
		.branchPredict(branchPredict),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.writeEn(writeEn),
		.ctrl(ctrl),
		.operands(operands),
		.memData(memData),
		.callCmd(callCmd),
		.nextPCOut(nextPCOut),
		.branchPredictOut(branchPredictOut),
		.instructionOut(instructionOut)
	);

	initial begin
		iClk = 1'b0;
		forever #50 iClk = ~iClk;
	end

	// Three rising edges in reset
	initial begin
		rstN = 1'b0;
		repeat (3) @(negedge iClk);
		rstN = 1'b1;
	end

	task automatic checkWord(input string name, input dataT got, input dataT exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic checkCtrl(input string name, input ctrlT got, input ctrlT exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic waitForReset(output logic released);
		int cycles;
		cycles = 0;
		while (rstN !== 1'b1 && cycles < 20) begin
			@(posedge iClk);
			cycles++;
		end
		released = (rstN === 1'b1);
	endtask

	// Drive on the falling edge and let outputs settle before the next rising edge
	task automatic present(input dataT instr, input dataT pc, input logic bp);
		@(negedge iClk);
		instruction = instr;
		nextPC = pc;
		branchPredict = bp;
		#10;
	endtask

	task automatic writeReg(input regAddrT addr, input dataT data);
		@(negedge iClk);
		writeEn = 1'b1;
		writeAddr = addr;
		writeData = data;
		@(negedge iClk);
		writeEn = 1'b0;
		if (addr != 5'd0)
			model[addr] = data;
	endtask

	function automatic dataT rType(functE fn, regAddrT rs, regAddrT rt, regAddrT rd,
			logic [4:0] shamt);
		return {opRType, rs, rt, rd, shamt, fn};
	endfunction

	function automatic dataT iType(opcodeE op, regAddrT rs, regAddrT rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic functE nthFunct(int i);
		case (i)
			0: return fnSll;
			1: return fnSrl;
			2: return fnAdd;
			3: return fnSub;
			4: return fnAnd;
			5: return fnOr;
			6: return fnXor;
			default: return fnSlt;
		endcase
	endfunction

	function automatic ctrlT expectRType(functE fn, regAddrT rd, logic [4:0] shamt);
		ctrlT c;
		c = '0;
		c.aluCmd = 1'b1;
		c.writeAddr = rd;
		c.writeEn = 1'b1;
		case (fn)
			fnAdd: c.aluOp = aluAdd;
			fnSub: c.aluOp = aluSub;
			fnSlt: c.aluOp = aluSlt;
			fnAnd: c.aluOp = aluAnd;
			fnOr: c.aluOp = aluOr;
			fnXor: c.aluOp = aluXor;
			fnSll: c.aluOp = aluSll;
			default: c.aluOp = aluSrl;
		endcase
		if (fn == fnAdd || fn == fnSub || fn == fnSlt) begin
			c.zeroEn = 1'b1;
			c.overflowEn = 1'b1;
			c.negativeEn = 1'b1;
		end else if (fn == fnAnd || fn == fnOr || fn == fnXor) begin
			c.zeroEn = 1'b1;
		end else begin
			c.exuOp = exuShifter;
			c.exuShift = shamt;
		end
		return c;
	endfunction

	// Memory and control transfer bundles
	function automatic ctrlT expectOther(opcodeE op, regAddrT rt);
		ctrlT c;
		c = '0;
		case (op)
			opLoad: begin
				c.exuOp = exuMemory;
				c.loadCmd = 1'b1;
				c.memValid = 1'b1;
				c.memToReg = 1'b1;
				c.writeAddr = rt;
				c.writeEn = 1'b1;
			end
			opStore: begin
				c.exuOp = exuMemory;
				c.storeCmd = 1'b1;
				c.memWrite = 1'b1;
				c.memValid = 1'b1;
			end
			opBeq, opBne: begin
				c.aluOp = aluSub;
				c.exuOp = exuControl;
				c.branchOp = (op == opBeq) ? brEq : brNe;
				c.branchCmd = 1'b1;
			end
			opCall, opRet: begin
				c.exuOp = exuControl;
				c.branchOp = brAlways;
				c.memValid = 1'b1;
				c.retCmd = (op == opRet);
			end
			default: ;
		endcase
		return c;
	endfunction

	task automatic testAfterReset();
		for (int i = 0; i < 32; i++) begin
			present(rType(fnAdd, regAddrT'(i), regAddrT'(31 - i), 5'd1, 5'd0), 32'h0, 1'b0);
			checkWord("operands.src0", operands.src0, '0);
			checkWord("operands.src1", operands.src1, '0);
		end
	endtask

	task automatic testRegisterWriteRead();
		dataT fresh;
		for (int i = 1; i < 8; i++) begin
			writeReg(regAddrT'(i), $random(seed));
		end
		for (int i = 1; i < 7; i++) begin
			present(rType(fnAdd, regAddrT'(i), regAddrT'(i + 1), 5'd9, 5'd0), 32'h100, 1'b0);
			checkWord("operands.src0", operands.src0, model[i]);
			checkWord("operands.src1", operands.src1, model[i + 1]);
		end
		// Read r10 in the cycle it is written
		fresh = $random(seed);
		@(negedge iClk);
		writeEn = 1'b1;
		writeAddr = 5'd10;
		writeData = fresh;
		instruction = rType(fnOr, 5'd10, 5'd3, 5'd9, 5'd0);
		#10;
		checkWord("operands.src0", operands.src0, fresh);
		checkWord("operands.src1", operands.src1, model[3]);
		@(negedge iClk);
		writeEn = 1'b0;
		model[10] = fresh;
		present(rType(fnXor, 5'd3, 5'd10, 5'd9, 5'd0), 32'h104, 1'b0);
		checkWord("operands.src1", operands.src1, fresh);
	endtask

	task automatic testZeroRegister();
		writeReg(5'd0, $random(seed));
		present(rType(fnAdd, 5'd0, 5'd0, 5'd4, 5'd0), 32'h108, 1'b0);
		checkWord("operands.src0", operands.src0, '0);
		checkWord("operands.src1", operands.src1, '0);
		// rs and rt fields name written registers, yet jump reads nothing
		present({opJump, 5'd1, 5'd2, 16'h1234}, 32'h10c, 1'b0);
		checkWord("operands.src0", operands.src0, '0);
		checkWord("operands.src1", operands.src1, '0);
	endtask

	task automatic testRTypeControl();
		functE fn;
		logic [4:0] shamt;
		regAddrT rd;
		for (int i = 0; i < 8; i++) begin
			fn = nthFunct(i);
			shamt = 5'($random(seed));
			rd = regAddrT'(11 + i);
			present(rType(fn, 5'd1, 5'd2, rd, shamt), 32'h200, 1'b0);
			checkCtrl("ctrl", ctrl, expectRType(fn, rd, shamt));
			if (fn == fnSll || fn == fnSrl)
				checkWord("operands.src0", operands.src0, '0);
			else
				checkWord("operands.src0", operands.src0, model[1]);
			checkWord("operands.src1", operands.src1, model[2]);
		end
	endtask

	task automatic testBranchTarget();
		logic [15:0] imm;
		dataT pc;
		dataT ext;
		dataT instr;
		opcodeE op;
		for (int i = 0; i < 8; i++) begin
			// Immediate field and its sign-extended word
			case (i % 4)
				0: begin
					imm = 16'h0004;
					ext = 32'h0000_0004;
				end
				1: begin
					imm = 16'hfffc;
					ext = 32'hffff_fffc;
				end
				2: begin
					imm = 16'h7fff;
					ext = 32'h0000_7fff;
				end
				default: begin
					imm = 16'h8000;
					ext = 32'hffff_8000;
				end
			endcase
			op = (i < 4) ? opBeq : opBne;
			pc = $random(seed) & 32'hffff_fffc;
			instr = iType(op, 5'd5, 5'd6, imm);
			present(instr, pc, i[0]);
			checkCtrl("ctrl", ctrl, expectOther(op, 5'd6));
			checkWord("operands.immediate", operands.immediate, ext);
			checkWord("operands.branchAddr", operands.branchAddr, pc + ext * 32'd4);
			checkBit("branchPredictOut", branchPredictOut, i[0]);
			checkWord("nextPCOut", nextPCOut, pc);
			checkWord("instructionOut", instructionOut, instr);
		end
	endtask

	task automatic testLoadStore();
		dataT instr;
		present(iType(opLoad, 5'd3, 5'd12, 16'h0010), 32'h300, 1'b0);
		checkCtrl("ctrl", ctrl, expectOther(opLoad, 5'd12));
		checkWord("operands.src0", operands.src0, model[3]);
		present(iType(opStore, 5'd3, 5'd4, 16'hfff0), 32'h304, 1'b0);
		checkCtrl("ctrl", ctrl, expectOther(opStore, 5'd4));
		checkWord("memData", memData, model[4]);
		checkBit("callCmd", callCmd, 1'b0);
		// Opcode 1 is not assigned
		instr = $random(seed);
		instr[31:26] = 6'd1;
		present(instr, 32'h308, 1'b0);
		checkCtrl("ctrl", ctrl, '0);
	endtask

	task automatic testCallReturn();
		dataT callPC;
		callPC = $random(seed) & 32'hffff_fffc;
		present(rType(fnAdd, 5'd1, 5'd2, 5'd3, 5'd0), callPC - 32'd4, 1'b0);
		present({opCall, 26'h0000040}, callPC, 1'b0);
		checkBit("callCmd", callCmd, 1'b0);
		checkCtrl("ctrl", ctrl, expectOther(opCall, 5'd0));
		present({opRet, 26'h0}, callPC + 32'h40, 1'b0);
		checkBit("callCmd", callCmd, 1'b1);
		checkWord("memData", memData, callPC);
		checkCtrl("ctrl", ctrl, expectOther(opRet, 5'd0));
		present(rType(fnAdd, 5'd1, 5'd2, 5'd3, 5'd0), callPC + 32'h44, 1'b0);
		checkBit("callCmd", callCmd, 1'b0);
	endtask

	initial begin
		seed = 13;
		errors = 0;
		timeouts = 0;
		instruction = '0;
		nextPC = '0;
		branchPredict = 1'b0;
		writeAddr = '0;
		writeData = '0;
		writeEn = 1'b0;
		for (int i = 0; i < 32; i++) begin
			model[i] = '0;
		end
		waitForReset(resetDone);
		if (resetDone) begin
			testAfterReset();
			testRegisterWriteRead();
			testZeroRegister();
			testRTypeControl();
			testBranchTarget();
			testLoadStore();
			testCallReturn();
		end else begin
			timeouts++;
			$display("Reset was not released within 20 clock cycles");
		end
		$display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
